// ==== fib_config.svh ====
// FIB width settings
`ifndef FIB_CONFIG_SVH
`define FIB_CONFIG_SVH

// Prefix geometry
`define FIB_PREFIX_BYTES 8
`define FIB_PREFIX_W 64

// Length field and hash index widths
`define FIB_LEN_W 6
`define FIB_HASH_W 10

// Stream byte and SPI reply size
`define FIB_BYTE_W 8
`define FIB_TX_BYTES 17

`endif

// ==== fib_pkg.sv ====
// FIB shared types
`default_nettype none
`include "fib_config.svh"

package fib_pkg;

    // Metadata byte as seen on the stream
    typedef struct packed {
        logic                  reserved;
        logic                  interest;
        logic [`FIB_LEN_W-1:0] length;
    } fib_meta_t;

    typedef logic [`FIB_PREFIX_W-1:0] fib_prefix_t;
    typedef logic [`FIB_HASH_W-1:0]   fib_hash_t;

    // Metadata plus prefix, PIT request and announce
    typedef struct packed {
        fib_meta_t   meta;
        fib_prefix_t prefix;
    } fib_req_t;

    // Bitmap address, length row then hash column
    typedef struct packed {
        logic [`FIB_LEN_W-1:0] length;
        fib_hash_t             hash;
    } fib_addr_t;

    // SPI reply in wire order
    typedef struct packed {
        fib_meta_t   meta;
        fib_prefix_t total;
        fib_prefix_t longest;
    } fib_reply_t;

    // Key at length L keeps bits below L only
    function automatic fib_prefix_t key_at_len(input fib_prefix_t prefix,
                                               input logic [`FIB_LEN_W-1:0] len);
        fib_prefix_t mask;
        mask = (fib_prefix_t'(1) << len) - fib_prefix_t'(1);
        return prefix & mask;
    endfunction

endpackage

`default_nettype wire

// ==== prefix_hash.sv ====
// Prefix fold hash
`timescale 1ns/10ps
`default_nettype none
`include "fib_config.svh"

module prefix_hash (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire fib_pkg::fib_prefix_t key,
    output fib_pkg::fib_hash_t        hash
);

    // Full hash-wide slices, the leftover top bits fold in zero-extended
    localparam int SLICES = `FIB_PREFIX_W / `FIB_HASH_W;

    fib_pkg::fib_hash_t fold;

    always_comb begin
        fold = '0;
        for (int i = 0; i < SLICES; i++) begin
            fold = fold ^ key[i*`FIB_HASH_W +: `FIB_HASH_W];
        end
        // Bits 60 to 63
        fold = fold ^ fib_pkg::fib_hash_t'(key[`FIB_PREFIX_W-1:SLICES*`FIB_HASH_W]);
    end

    // One cycle of latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= fold;
        end
    end

endmodule

`default_nettype wire

// ==== fib_bitmap.sv ====
// FIB valid-bit table
`timescale 1ns/10ps
`default_nettype none
`include "fib_config.svh"

module fib_bitmap (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              learn_we,
    input  wire fib_pkg::fib_addr_t learn_addr,
    input  wire fib_pkg::fib_addr_t probe_addr,
    output logic                   probe_hit
);

    localparam int LENGTHS = 1 << `FIB_LEN_W;
    localparam int HASHES  = 1 << `FIB_HASH_W;

    // One row per prefix length, one bit per hash value
    logic [HASHES-1:0] valid_bits [LENGTHS];

    // Bits only ever get set, reset wipes the whole table
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < LENGTHS; i++) begin
                valid_bits[i] <= '0;
            end
        end else if (learn_we) begin
            valid_bits[learn_addr.length][learn_addr.hash] <= 1'b1;
        end
    end

    // Lookup side reads without a clock
    assign probe_hit = valid_bits[probe_addr.length][probe_addr.hash];

    // Write enable must be clean once out of reset
    a_learn_we_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(learn_we)
    );

endmodule

`default_nettype wire

// ==== interest_receiver.sv ====
// Interest packet receiver
`timescale 1ns/10ps
`default_nettype none
`include "fib_config.svh"

module interest_receiver (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   rx_valid,
    input  wire logic [`FIB_BYTE_W-1:0] rx_data,
    output fib_pkg::fib_req_t            pit_out,
    output logic                        prefix_ready,
    output logic                        learn_we,
    output fib_pkg::fib_addr_t           learn_addr
);

    localparam int CNT_W = $clog2(`FIB_PREFIX_BYTES + 1);

    logic [CNT_W-1:0]     byte_cnt;
    fib_pkg::fib_meta_t   meta_q;
    fib_pkg::fib_prefix_t prefix_sr;
    fib_pkg::fib_prefix_t key;
    fib_pkg::fib_hash_t   hash;
    logic                 learning;
    logic                 accept;
    logic                 last_byte;

    // Hash cycle, then write cycle; the stream is not taken meanwhile
    assign learning  = prefix_ready || learn_we;
    assign accept    = rx_valid && !learning;
    assign last_byte = accept && (byte_cnt == CNT_W'(`FIB_PREFIX_BYTES));

    // Byte 0 is metadata, 1 to 8 the prefix
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_cnt     <= '0;
            prefix_ready <= 1'b0;
            learn_we     <= 1'b0;
        end else begin
            prefix_ready <= last_byte && meta_q.interest;
            learn_we     <= prefix_ready;
            if (accept) begin
                byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
            end
        end
    end

    // Prefix arrives MSB first
    always_ff @(posedge clk) begin
        if (accept) begin
            if (byte_cnt == '0) begin
                meta_q <= fib_pkg::fib_meta_t'(rx_data);
            end else begin
                prefix_sr <= {prefix_sr[`FIB_PREFIX_W-`FIB_BYTE_W-1:0], rx_data};
            end
        end
        // Announce register holds until the next interest
        if (last_byte && meta_q.interest) begin
            pit_out.meta   <= meta_q;
            pit_out.prefix <= {prefix_sr[`FIB_PREFIX_W-`FIB_BYTE_W-1:0], rx_data};
        end
    end

    // Masked key goes in while prefix_ready is up
    assign key = fib_pkg::key_at_len(pit_out.prefix, pit_out.meta.length);

    prefix_hash u_hash (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .hash (hash)
    );

    assign learn_addr.length = pit_out.meta.length;
    assign learn_addr.hash   = hash;

    a_ready_pulse: assert property (
        @(posedge clk) disable iff (rst) prefix_ready |=> !prefix_ready
    );

    // Sender has to leave a gap after each interest
    a_no_rx_while_learning: assert property (
        @(posedge clk) disable iff (rst) learning |-> !rx_valid
    );

endmodule

`default_nettype wire

// ==== lpm_lookup.sv ====
// Longest prefix search
`timescale 1ns/10ps
`default_nettype none
`include "fib_config.svh"

module lpm_lookup (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              fib_out,
    input  wire fib_pkg::fib_req_t  pit_in,
    input  wire logic              tx_busy,
    output fib_pkg::fib_addr_t      probe_addr,
    input  wire logic              probe_hit,
    output logic                   reply_valid,
    output fib_pkg::fib_reply_t     reply
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HASH,
        ST_CHECK
    } state_t;

    state_t                state;
    fib_pkg::fib_meta_t    meta_q;
    fib_pkg::fib_prefix_t  prefix_q;
    logic [`FIB_LEN_W-1:0] len_q;
    fib_pkg::fib_prefix_t  key;
    fib_pkg::fib_hash_t    hash;
    logic                  start;
    logic                  found;

    // Requests during a search or a transmission are dropped
    assign start = (state == ST_IDLE) && fib_out && !tx_busy && !reply_valid;
    // Stop on a hit or once length 0 has been probed
    assign found = (state == ST_CHECK) && (probe_hit || len_q == '0);

    assign key = fib_pkg::key_at_len(prefix_q, len_q);

    prefix_hash u_hash (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .hash (hash)
    );

    assign probe_addr.length = len_q;
    assign probe_addr.hash   = hash;

    // Two cycles per probed length
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ST_IDLE;
            len_q       <= '0;
            reply_valid <= 1'b0;
        end else begin
            reply_valid <= found;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        len_q <= pit_in.meta.length;
                        state <= ST_HASH;
                    end
                end
                ST_HASH: state <= ST_CHECK;
                ST_CHECK: begin
                    if (found) begin
                        state <= ST_IDLE;
                    end else begin
                        // Drop one bit and try again
                        len_q <= len_q - 1'b1;
                        state <= ST_HASH;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            meta_q   <= pit_in.meta;
            prefix_q <= pit_in.prefix;
        end
        if (found) begin
            reply.meta    <= meta_q;
            reply.total   <= prefix_q;
            reply.longest <= key;
        end
    end

    // Transmitter must be free whenever a reply comes out
    a_reply_not_busy: assert property (
        @(posedge clk) disable iff (rst) !(reply_valid && tx_busy)
    );

endmodule

`default_nettype wire

// ==== spi_packet_tx.sv ====
// SPI reply serializer
`timescale 1ns/10ps
`default_nettype none
`include "fib_config.svh"

module spi_packet_tx (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 reply_valid,
    input  wire fib_pkg::fib_reply_t   reply,
    output logic                      tx_busy,
    output logic                      spi_flag,
    output logic [`FIB_BYTE_W-1:0]    spi_data
);

    localparam int CNT_W   = $clog2(`FIB_TX_BYTES + 1);
    localparam int REPLY_W = `FIB_TX_BYTES * `FIB_BYTE_W;

    logic [CNT_W-1:0]   bytes_left;
    logic [REPLY_W-1:0] shift_q;

    // Flag cycle, then the bytes back to back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            spi_flag   <= 1'b0;
            bytes_left <= '0;
        end else begin
            spi_flag <= reply_valid;
            if (reply_valid) begin
                bytes_left <= CNT_W'(`FIB_TX_BYTES);
            end else if (bytes_left != '0) begin
                bytes_left <= bytes_left - 1'b1;
            end
        end
    end

    // Metadata first, then total and longest prefix, MSB first
    always_ff @(posedge clk) begin
        if (reply_valid) begin
            shift_q <= reply;
        end else if (bytes_left != '0) begin
            spi_data <= shift_q[REPLY_W-1 -: `FIB_BYTE_W];
            shift_q  <= shift_q << `FIB_BYTE_W;
        end
    end

    // Drops while the last byte is on the bus
    assign tx_busy = (bytes_left != '0);

endmodule

`default_nettype wire

// ==== fib_table.sv ====
// FIB core top level
`timescale 1ns/10ps
`default_nettype none
`include "fib_config.svh"

module fib_table (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   rx_valid,
    input  wire logic [`FIB_BYTE_W-1:0] rx_data,
    input  wire fib_pkg::fib_req_t       pit_in,
    input  wire logic                   fib_out,
    output fib_pkg::fib_req_t            pit_out,
    output logic                        prefix_ready,
    output logic                        spi_flag,
    output logic [`FIB_BYTE_W-1:0]      spi_data
);

    // Learn port
    logic               learn_we;
    fib_pkg::fib_addr_t learn_addr;
    // Probe port
    fib_pkg::fib_addr_t probe_addr;
    logic               probe_hit;
    // Lookup to transmitter
    logic                reply_valid;
    fib_pkg::fib_reply_t reply;
    logic                tx_busy;

    fib_bitmap u_bitmap (
        .clk        (clk),
        .rst        (rst),
        .learn_we   (learn_we),
        .learn_addr (learn_addr),
        .probe_addr (probe_addr),
        .probe_hit  (probe_hit)
    );

    interest_receiver u_rx (
        .clk          (clk),
        .rst          (rst),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .pit_out      (pit_out),
        .prefix_ready (prefix_ready),
        .learn_we     (learn_we),
        .learn_addr   (learn_addr)
    );

    lpm_lookup u_lookup (
        .clk         (clk),
        .rst         (rst),
        .fib_out     (fib_out),
        .pit_in      (pit_in),
        .tx_busy     (tx_busy),
        .probe_addr  (probe_addr),
        .probe_hit   (probe_hit),
        .reply_valid (reply_valid),
        .reply       (reply)
    );

    spi_packet_tx u_tx (
        .clk         (clk),
        .rst         (rst),
        .reply_valid (reply_valid),
        .reply       (reply),
        .tx_busy     (tx_busy),
        .spi_flag    (spi_flag),
        .spi_data    (spi_data)
    );

endmodule

`default_nettype wire

// ==== tb_fib_table.sv ====
// FIB core testbench
`timescale 1ns/10ps
`default_nettype none
`include "fib_config.svh"

module tb_fib_table;

    localparam int CLK_PERIOD   = 4;
    localparam int REPLY_W      = `FIB_TX_BYTES * `FIB_BYTE_W;
    localparam int LENGTHS      = 1 << `FIB_LEN_W;
    localparam int HASHES       = 1 << `FIB_HASH_W;
    // Two cycles per probed length, plus flag, bytes and idle
    localparam int LOOKUP_LIMIT = LENGTHS * 2 + 30;
    localparam int N_LOOKUPS    = 24;
    localparam int N_PACKETS    = 23;
    localparam int WATCHDOG_CYC = LOOKUP_LIMIT * N_LOOKUPS + 20 * N_PACKETS;
    localparam int N_RANDOM     = 20;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    rx_valid;
    logic [`FIB_BYTE_W-1:0]  rx_data;
    fib_pkg::fib_req_t       pit_in;
    logic                    fib_out;
    fib_pkg::fib_req_t       pit_out;
    logic                    prefix_ready;
    logic                    spi_flag;
    logic [`FIB_BYTE_W-1:0]  spi_data;

    // Testbench copy of the valid bits
    logic [HASHES-1:0] model_bits [LENGTHS];

    fib_table dut0 (
        .clk          (clk),
        .rst          (rst),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .pit_in       (pit_in),
        .fib_out      (fib_out),
        .pit_out      (pit_out),
        .prefix_ready (prefix_ready),
        .spi_flag     (spi_flag),
        .spi_data     (spi_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fold of six 10-bit slices and the top four bits
    function automatic logic [`FIB_HASH_W-1:0] fold_hash(input logic [`FIB_PREFIX_W-1:0] key);
        logic [`FIB_HASH_W-1:0] h;
        h = '0;
        for (int s = 0; s < 7; s++) begin
            h = h ^ `FIB_HASH_W'(key >> (`FIB_HASH_W * s));
        end
        return h;
    endfunction

    // Keep bits 0 to len-1 of the prefix
    function automatic logic [`FIB_PREFIX_W-1:0] masked_key(input logic [`FIB_PREFIX_W-1:0] prefix,
                                                            input int len);
        logic [`FIB_PREFIX_W-1:0] k;
        k = '0;
        for (int b = 0; b < len; b++) begin
            k[b] = prefix[b];
        end
        return k;
    endfunction

    // First hit walking down from len, zero key if none
    function automatic logic [`FIB_PREFIX_W-1:0] first_hit_key(
        input logic [`FIB_PREFIX_W-1:0] prefix, input int len);
        logic [`FIB_PREFIX_W-1:0] k;
        for (int l = len; l > 0; l--) begin
            k = masked_key(prefix, l);
            if (model_bits[l][fold_hash(k)]) begin
                return k;
            end
        end
        return '0;
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic value_error(input string msg);
        $display("ERROR @ %0t: %s", $time, msg);
        abort_run();
    endtask

    // Inputs change half a ns past the edge
    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic send_packet(input logic [`FIB_BYTE_W-1:0] meta,
                               input logic [`FIB_PREFIX_W-1:0] prefix);
        int   pulses;
        logic interest;
        int   len;
        pulses   = 0;
        interest = meta[6];
        len      = int'(meta[`FIB_LEN_W-1:0]);
        // Metadata, then prefix MSB first
        for (int i = 0; i < 9; i++) begin
            rx_valid = 1'b1;
            if (i == 0) begin
                rx_data = meta;
            end else begin
                rx_data = `FIB_BYTE_W'(prefix >> (`FIB_BYTE_W * (9 - i - 1)));
            end
            step();
            if (i < 8 && prefix_ready) begin
                pulses++;
            end
        end
        rx_valid = 1'b0;
        rx_data  = '0;
        assert (prefix_ready === interest) else
            value_error($sformatf("prefix_ready after last byte is %b, expected %b",
                                  prefix_ready, interest));
        if (interest) begin
            assert (pit_out === fib_pkg::fib_req_t'({meta, prefix})) else
                value_error($sformatf("pit_out %h, expected %h", pit_out, {meta, prefix}));
            model_bits[len][fold_hash(masked_key(prefix, len))] = 1'b1;
        end
        pulses += int'(prefix_ready);
        // Learn cycles, stream held idle
        repeat (3) begin
            step();
            pulses += int'(prefix_ready);
        end
        assert (pulses == int'(interest)) else
            value_error($sformatf("%0d prefix_ready cycles, expected %0d", pulses, interest));
    endtask

    task automatic lookup(input logic [`FIB_BYTE_W-1:0] meta,
                          input logic [`FIB_PREFIX_W-1:0] prefix);
        logic [`FIB_PREFIX_W-1:0] longest;
        logic [REPLY_W-1:0]       expected;
        logic [REPLY_W-1:0]       got;
        int                       waited;
        longest  = first_hit_key(prefix, int'(meta[`FIB_LEN_W-1:0]));
        expected = {meta, prefix, longest};
        got      = '0;
        pit_in   = fib_pkg::fib_req_t'({meta, prefix});
        fib_out  = 1'b1;
        step();
        fib_out = 1'b0;
        waited  = 0;
        while (spi_flag !== 1'b1 && waited < LOOKUP_LIMIT) begin
            step();
            waited++;
        end
        if (spi_flag !== 1'b1) begin
            $display("Lookup never raised spi_flag within %0d cycles", LOOKUP_LIMIT);
            abort_run();
        end
        // Reply bytes on the cycles right after the flag
        for (int b = 0; b < `FIB_TX_BYTES; b++) begin
            step();
            got = {got[REPLY_W-`FIB_BYTE_W-1:0], spi_data};
        end
        assert (got === expected) else
            value_error($sformatf("reply %h, expected %h", got, expected));
        repeat (3) step();
    endtask

    task automatic after_reset();
        assert (prefix_ready === 1'b0) else
            value_error($sformatf("prefix_ready is %b after reset", prefix_ready));
        assert (spi_flag === 1'b0) else
            value_error($sformatf("spi_flag is %b after reset", spi_flag));
        // Empty table walks all the way to length 0
        lookup({2'b01, 6'd40}, {$urandom, $urandom});
    endtask

    task automatic announce_and_exact_match();
        logic [`FIB_PREFIX_W-1:0] p;
        p = 64'hc3a5_1f00_7e29_b4d6;
        send_packet({2'b01, 6'd30}, p);
        lookup({2'b01, 6'd30}, p);
    endtask

    task automatic shorter_match();
        logic [`FIB_PREFIX_W-1:0] q;
        q = 64'h5b17_e8c2_94af_03d1;
        send_packet({2'b01, 6'd20}, q);
        lookup({2'b01, 6'd50}, q);
    endtask

    task automatic non_interest_packet();
        logic [`FIB_PREFIX_W-1:0] r;
        fib_pkg::fib_req_t        held;
        r    = 64'h0f2e_6d4c_8b3a_a917;
        held = pit_out;
        send_packet({2'b00, 6'd25}, r);
        // Announce register untouched
        assert (pit_out === held) else
            value_error($sformatf("pit_out changed to %h on a non-interest packet", pit_out));
        lookup({2'b01, 6'd25}, r);
    endtask

    task automatic random_mix();
        logic [`FIB_PREFIX_W-1:0] learned_prefix [N_RANDOM];
        int                       learned_len [N_RANDOM];
        logic [`FIB_PREFIX_W-1:0] p;
        int                       j;
        int                       len;
        for (int i = 0; i < N_RANDOM; i++) begin
            learned_prefix[i] = {$urandom, $urandom};
            learned_len[i]    = int'($urandom % LENGTHS);
            send_packet({2'b01, `FIB_LEN_W'(learned_len[i])}, learned_prefix[i]);
            // Mostly revisit a learned prefix at an equal or longer length
            j   = int'($urandom % (i + 1));
            len = learned_len[j] + int'($urandom % (LENGTHS - learned_len[j]));
            p   = learned_prefix[j];
            if ($urandom % 4 == 0) begin
                p = {$urandom, $urandom};
            end
            lookup({2'b01, `FIB_LEN_W'(len)}, p);
        end
    endtask

    initial begin
        void'($urandom(32'h92e5a4fd));
        for (int l = 0; l < LENGTHS; l++) begin
            model_bits[l] = '0;
        end
        rst      = 1'b1;
        rx_valid = 1'b0;
        rx_data  = '0;
        pit_in   = '0;
        fib_out  = 1'b0;
        repeat (2) @(posedge clk);
        #0.5;
        rst = 1'b0;
        after_reset();
        announce_and_exact_match();
        shorter_match();
        non_interest_packet();
        random_mix();
        $display("STATUS: PASS");
        $finish;
    end

    // Bound on the whole run
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Simulation timed out after %0d cycles", WATCHDOG_CYC);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
fib_pkg.sv
prefix_hash.sv
fib_bitmap.sv
interest_receiver.sv
lpm_lookup.sv
spi_packet_tx.sv
fib_table.sv
tb_fib_table.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the FIB testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_fib_table --Mdir obj_dir -o sim_fib_table
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_fib_table 2>&1)"
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
